//--- Bender.yml
package:
  name: soc_sysctl

sources:
  - design/soc_bus_pkg.sv
  - design/soc_map_pkg.sv
  - design/pi1_if.sv
  - design/rst_seq.sv
  - design/pi1_router.sv
  - design/dev_table.sv
  - design/int_ctrl.sv
  - design/soc_top.sv
  - target: test
    files:
      - tb/tb_soc_top.sv

//--- design/dev_table.sv
module dev_table (
	input  logic  clk48mhz_i,
	input  logic  rst_p,
	pi1_if.slave  bus,
	output logic  rst0_o,
	output logic  rst1_o
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [1:0]            rstctl_q;
	logic [PI1_SLOT_W-1:0] idx;
	logic                  in_table;
	logic                  rstctl_wr;
	logic [PI1_DATA_W-1:0] rd_word;

	// Two words per slot: id then map size
	assign idx      = bus.addr[PI1_SLOT_W:1];
	assign in_table = (bus.addr < PI1_OFFSET_W'(2 * SLOT_COUNT));

	always_comb begin
		rd_word = '0;
		if (in_table) begin
			if (bus.addr[0]) begin
				rd_word = DEV_MAPSZ[idx];
			end else begin
				rd_word = {DEV_USEINTR[idx], DEV_ID[idx][PI1_DATA_W-2:0]};
			end
		end else if (bus.addr == DEVTBL_RSTCTL_OFS) begin
			rd_word[1:0] = rstctl_q;
		end
	end

	assign rstctl_wr = op_writes(bus.op) && (bus.addr == DEVTBL_RSTCTL_OFS) && bus.sel[0];

	// Cleared by the system reset it requests
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			rstctl_q <= 2'b00;
		end else if (rstctl_wr) begin
			rstctl_q <= bus.wdata[1:0];
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (op_reads(bus.op)) begin
			bus.rdata <= rd_word;
		end
	end

	assign rst0_o = rstctl_q[0];
	assign rst1_o = rstctl_q[1];

endmodule

//--- design/int_ctrl.sv
module int_ctrl (
	input  logic                                  clk48mhz_i,
	input  logic                                  rst_p,
	pi1_if.slave                                  bus,
	input  logic [soc_map_pkg::INT_SRC_COUNT-1:0] intrqst_src_i,
	output logic [soc_map_pkg::INT_SRC_COUNT-1:0] intrdy_src_o,
	output logic                                  intrqst_o,
	input  logic                                  intrdy_i
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [INT_SRC_COUNT-1:0] pend_q;
	logic [INT_SRC_COUNT-1:0] mask_q;
	logic [INT_SRC_COUNT-1:0] active;
	logic [INT_SRC_COUNT-1:0] claim_oh;
	logic [PI1_DATA_W-1:0]    claim_word;
	logic [PI1_DATA_W-1:0]    rd_word;
	logic                     claim_rd;
	logic                     mask_wr;

	assign active = pend_q & mask_q;

	// Lowest enabled pending source wins
	always_comb begin
		claim_word = INT_NONE;
		claim_oh   = '0;
		for (int i = INT_SRC_COUNT - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_word = PI1_DATA_W'(i);
				claim_oh   = INT_SRC_COUNT'(1) << i;
			end
		end
	end

	assign claim_rd = op_reads(bus.op) && (bus.addr == INTCTRL_CLAIM_OFS);
	assign mask_wr  = op_writes(bus.op) && (bus.addr == INTCTRL_MASK_OFS) && bus.sel[0];

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pend_q       <= '0;
			mask_q       <= '0;
			intrdy_src_o <= '0;
		end else begin
			// A source still asserting keeps its pending bit
			pend_q       <= (pend_q & ~(claim_rd ? claim_oh : '0)) | intrqst_src_i;
			intrdy_src_o <= claim_rd ? claim_oh : '0;
			if (mask_wr) begin
				mask_q <= bus.wdata[INT_SRC_COUNT-1:0];
			end
		end
	end

	always_comb begin
		rd_word = '0;
		if (bus.addr == INTCTRL_CLAIM_OFS) begin
			rd_word = claim_word;
		end else if (bus.addr == INTCTRL_MASK_OFS) begin
			rd_word[INT_SRC_COUNT-1:0] = mask_q;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (op_reads(bus.op)) begin
			bus.rdata <= rd_word;
		end
	end

	assign intrqst_o = (|active) & intrdy_i;

	a_ack_onehot: assert property (@(posedge clk48mhz_i) $onehot0(intrdy_src_o))
		else $error("More than one source acknowledged");

endmodule

//--- design/pi1_if.sv
interface pi1_if;
	import soc_bus_pkg::*;

	pi1_op_t                 op;
	// Only the offset within the slot reaches the slave
	logic [PI1_OFFSET_W-1:0] addr;
	logic [PI1_DATA_W-1:0]   wdata;
	logic [PI1_SEL_W-1:0]    sel;
	// Registered by the slave on the request edge
	logic [PI1_DATA_W-1:0]   rdata;

	modport master (
		output op, addr, wdata, sel,
		input  rdata
	);

	modport slave (
		input  op, addr, wdata, sel,
		output rdata
	);

endinterface

//--- design/pi1_router.sv
module pi1_router (
	input  logic                               clk48mhz_i,
	input  logic                               rst_p,
	input  soc_bus_pkg::pi1_op_t               op_i,
	input  soc_bus_pkg::pi1_addr_u             addr_i,
	input  logic [soc_bus_pkg::PI1_DATA_W-1:0] data_i,
	input  logic [soc_bus_pkg::PI1_SEL_W-1:0]  sel_i,
	output logic [soc_bus_pkg::PI1_DATA_W-1:0] data_o,
	pi1_if.master                              dev,
	pi1_if.master                              intc
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic                  region_ok;
	logic                  hit_dev;
	logic                  hit_intc;
	logic                  rd_valid_q;
	logic [PI1_SLOT_W-1:0] rd_slot_q;

	// Only region zero is mapped
	assign region_ok = (addr_i.fields.region == '0);
	assign hit_dev   = region_ok && (addr_i.fields.slot == SLOT_DEVTBL);
	assign hit_intc  = region_ok && (addr_i.fields.slot == SLOT_INTCTRL);

	// Steer the request, the idle link sees no op
	assign dev.op    = hit_dev ? op_i : PI1_OP_NONE;
	assign dev.addr  = addr_i.fields.offset;
	assign dev.wdata = data_i;
	assign dev.sel   = sel_i;

	assign intc.op    = hit_intc ? op_i : PI1_OP_NONE;
	assign intc.addr  = addr_i.fields.offset;
	assign intc.wdata = data_i;
	assign intc.sel   = sel_i;

	// Remember where a read went so the data can be picked next cycle
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= op_reads(op_i) && region_ok;
		end
		rd_slot_q <= addr_i.fields.slot;
	end

	// Unmapped slots return zero
	always_comb begin
		data_o = '0;
		if (rd_valid_q) begin
			case (rd_slot_q)
				SLOT_DEVTBL:  data_o = dev.rdata;
				SLOT_INTCTRL: data_o = intc.rdata;
				default:      data_o = '0;
			endcase
		end
	end

	a_one_link: assert property (@(posedge clk48mhz_i)
		$onehot0({dev.op != PI1_OP_NONE, intc.op != PI1_OP_NONE}))
		else $error("Both slave links active");

endmodule

//--- design/rst_seq.sv
module rst_seq #(
	parameter int RST_CNTR_BITSZ = 16
) (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  logic cpu_rst_req_i,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);

	logic [RST_CNTR_BITSZ-1:0] cntr;
	logic                      pwroff_q;
	logic                      sw_warm;
	logic                      sw_cold;
	logic                      sw_pwroff;
	logic                      restart;

	// Software requests from the two reset bits
	assign sw_cold   = rst0_i & rst1_i;
	assign sw_warm   = ~rst0_i & rst1_i;
	assign sw_pwroff = rst0_i & ~rst1_i;

	// No global reset primitive, so warm and cold both rerun the stretch
	assign restart = rst_p | cpu_rst_req_i | sw_warm | sw_cold;

	always_ff @(posedge clk48mhz_i) begin
		if (restart) begin
			cntr <= '1;
		end else if (cntr != '0) begin
			cntr <= cntr - 1'b1;
		end
	end

	// Power-off holds the system until the board reset
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = rst_p | (|cntr) | pwroff_q;

	a_rst_stretch: assert property (@(posedge clk48mhz_i) rst_p |=> sys_rst_o)
		else $error("sys_rst_o low right after rst_p");

endmodule

//--- design/soc_bus_pkg.sv
package soc_bus_pkg;

	// Peripheral bus geometry
	localparam int PI1_DATA_W = 32;
	localparam int PI1_SEL_W = PI1_DATA_W / 8;
	localparam int PI1_ADDR_W = 30;
	localparam int PI1_OFFSET_W = 10;
	localparam int PI1_SLOT_W = 3;
	localparam int PI1_REGION_W = PI1_ADDR_W - PI1_SLOT_W - PI1_OFFSET_W;

	// Swap is a read and a write in the same access
	typedef enum logic [1:0] {
		PI1_OP_NONE  = 2'd0,
		PI1_OP_WRITE = 2'd1,
		PI1_OP_READ  = 2'd2,
		PI1_OP_SWAP  = 2'd3
	} pi1_op_t;

	// Word address, either flat or split into region, slot and offset
	typedef union packed {
		logic [PI1_ADDR_W-1:0] flat;
		struct packed {
			logic [PI1_REGION_W-1:0] region;
			logic [PI1_SLOT_W-1:0]   slot;
			logic [PI1_OFFSET_W-1:0] offset;
		} fields;
	} pi1_addr_u;

	function automatic logic op_reads(pi1_op_t op);
		return (op == PI1_OP_READ) || (op == PI1_OP_SWAP);
	endfunction

	function automatic logic op_writes(pi1_op_t op);
		return (op == PI1_OP_WRITE) || (op == PI1_OP_SWAP);
	endfunction

endpackage

//--- design/soc_map_pkg.sv
package soc_map_pkg;

	// Device slots, everything else decodes to the catch-all
	localparam logic [soc_bus_pkg::PI1_SLOT_W-1:0] SLOT_DEVTBL = 3'd0;
	localparam logic [soc_bus_pkg::PI1_SLOT_W-1:0] SLOT_INTCTRL = 3'd1;
	localparam int SLOT_COUNT = 8;

	// Device table contents, one entry per slot
	localparam logic [soc_bus_pkg::PI1_DATA_W-1:0] DEV_ID [SLOT_COUNT] = '{
		SLOT_DEVTBL:  32'd7,
		SLOT_INTCTRL: 32'd3,
		default:      32'd0
	};
	localparam logic [soc_bus_pkg::PI1_DATA_W-1:0] DEV_MAPSZ [SLOT_COUNT] = '{
		SLOT_DEVTBL:  32'h1000,
		SLOT_INTCTRL: 32'h1000,
		default:      32'd0
	};
	localparam logic DEV_USEINTR [SLOT_COUNT] = '{default: 1'b0};

	// Interrupt controller
	localparam int INT_SRC_COUNT = 2;
	localparam logic [soc_bus_pkg::PI1_DATA_W-1:0] INT_NONE = '1;

	// Register offsets in words
	localparam logic [soc_bus_pkg::PI1_OFFSET_W-1:0] DEVTBL_RSTCTL_OFS = 10'd16;
	localparam logic [soc_bus_pkg::PI1_OFFSET_W-1:0] INTCTRL_CLAIM_OFS = 10'd0;
	localparam logic [soc_bus_pkg::PI1_OFFSET_W-1:0] INTCTRL_MASK_OFS = 10'd1;

endpackage

//--- design/soc_top.sv
module soc_top #(
	parameter int RST_CNTR_BITSZ = 16
) (
	input  logic                                  clk48mhz_i,
	input  logic                                  rst_p,
	input  logic                                  cpu_rst_req_i,
	input  soc_bus_pkg::pi1_op_t                  pi1_op_i,
	input  logic [soc_bus_pkg::PI1_ADDR_W-1:0]    pi1_addr_i,
	input  logic [soc_bus_pkg::PI1_DATA_W-1:0]    pi1_data_i,
	input  logic [soc_bus_pkg::PI1_SEL_W-1:0]     pi1_sel_i,
	output logic [soc_bus_pkg::PI1_DATA_W-1:0]    pi1_data_o,
	input  logic [soc_map_pkg::INT_SRC_COUNT-1:0] intrqst_src_i,
	output logic [soc_map_pkg::INT_SRC_COUNT-1:0] intrdy_src_o,
	output logic                                  intrqst_o,
	input  logic                                  intrdy_i,
	output logic                                  sys_rst_o
);

	logic rst0;
	logic rst1;

	pi1_if pi1_dev ();
	pi1_if pi1_int ();

	rst_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) u_rst_seq (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.cpu_rst_req_i (cpu_rst_req_i),
		.rst0_i        (rst0),
		.rst1_i        (rst1),
		.sys_rst_o     (sys_rst_o)
	);

	// Flat address port feeds the decoded view of the router
	pi1_router u_router (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (sys_rst_o),
		.op_i       (pi1_op_i),
		.addr_i     (pi1_addr_i),
		.data_i     (pi1_data_i),
		.sel_i      (pi1_sel_i),
		.data_o     (pi1_data_o),
		.dev        (pi1_dev.master),
		.intc       (pi1_int.master)
	);

	dev_table u_dev_table (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (sys_rst_o),
		.bus        (pi1_dev.slave),
		.rst0_o     (rst0),
		.rst1_o     (rst1)
	);

	int_ctrl u_int_ctrl (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (sys_rst_o),
		.bus           (pi1_int.slave),
		.intrqst_src_i (intrqst_src_i),
		.intrdy_src_o  (intrdy_src_o),
		.intrqst_o     (intrqst_o),
		.intrdy_i      (intrdy_i)
	);

endmodule

//--- flist.f
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/pi1_if.sv
design/rst_seq.sv
design/pi1_router.sv
design/dev_table.sv
design/int_ctrl.sv
design/soc_top.sv
tb/tb_soc_top.sv

//--- tb/tb_soc_top.sv
module tb_soc_top;
	import soc_bus_pkg::*;

	// Row control bits
	localparam logic [4:0] C_RST = 5'h01;
	localparam logic [4:0] C_CPU = 5'h02;
	localparam logic [4:0] C_RND = 5'h04;
	localparam logic [4:0] C_INC = 5'h08;
	localparam logic [4:0] C_NRDY = 5'h10;
	// Which outputs a row checks
	localparam logic [3:0] K_DATA = 4'h1;
	localparam logic [3:0] K_IRQ = 4'h2;
	localparam logic [3:0] K_SYS = 4'h4;
	localparam logic [3:0] K_ACK = 4'h8;
	localparam logic [3:0] K_ALL = 4'hF;
	localparam pi1_op_t NOP = PI1_OP_NONE;
	localparam pi1_op_t WR = PI1_OP_WRITE;
	localparam pi1_op_t RD = PI1_OP_READ;

	// Expected values describe what is seen in the cycle the row is driven
	typedef struct packed {
		logic [4:0]            ctl;
		pi1_op_t               op;
		logic [PI1_ADDR_W-1:0] addr;
		logic [PI1_DATA_W-1:0] wdata;
		logic [1:0]            src;
		logic [3:0]            chk;
		logic [PI1_DATA_W-1:0] e_data;
		logic                  e_irq;
		logic [1:0]            e_ack;
		logic                  e_sys;
		logic [7:0]            n;
	} row_t;

	logic                  clk48mhz_i = 1'b0;
	logic                  rst_p;
	logic                  cpu_rst_req_i;
	pi1_op_t               pi1_op_i;
	logic [PI1_ADDR_W-1:0] pi1_addr_i;
	logic [PI1_DATA_W-1:0] pi1_data_i;
	logic [PI1_SEL_W-1:0]  pi1_sel_i;
	logic [PI1_DATA_W-1:0] pi1_data_o;
	logic [1:0]            intrqst_src_i;
	logic [1:0]            intrdy_src_o;
	logic                  intrqst_o;
	logic                  intrdy_i;
	logic                  sys_rst_o;

	row_t        rows[$];
	logic [15:0] lfsr_q = 16'd971;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          limit;

	soc_top #(.RST_CNTR_BITSZ(4)) dut (.*);

	always #2 clk48mhz_i = ~clk48mhz_i;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One LFSR step per data bit
	task automatic draw_word(output logic [PI1_DATA_W-1:0] w);
		for (int b = 0; b < PI1_DATA_W; b++) begin
			w[b] = lfsr_q[0];
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at time %0t: %s got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	initial begin
		row_t        r;
		logic [31:0] wd;
		rst_p = 1'b1;
		cpu_rst_req_i = 1'b0;
		pi1_op_i = PI1_OP_NONE;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i = '1;
		intrqst_src_i = '0;
		intrdy_i = 1'b1;

		// Board reset followed by a 15 cycle stretch
		rows.push_back('{C_RST, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 1, 5});
		rows.push_back('{0, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 1, 15});
		rows.push_back('{0, NOP, 0, 0, 0, K_ALL, 0, 0, 0, 0, 1});
		// CPU reset request held for three cycles
		rows.push_back('{C_CPU, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 0, 1});
		rows.push_back('{C_CPU, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 1, 2});
		rows.push_back('{0, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 1, 15});
		rows.push_back('{0, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 0, 1});
		// Device table reads start at the empty slots
		// Each result shows one row later
		rows.push_back('{C_INC, RD, 'h004, 0, 0, K_DATA, 0, 0, 0, 0, 12});
		rows.push_back('{0, RD, 'h000, 0, 0, K_DATA, 0, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h001, 0, 0, K_DATA, 7, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h002, 0, 0, K_DATA, 'h1000, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h003, 0, 0, K_DATA, 3, 0, 0, 0, 1});
		// Reads at a nonzero region and at slots 2 and 7
		rows.push_back('{0, RD, 'h2000, 0, 0, K_DATA, 'h1000, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h0800, 0, 0, K_DATA, 0, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h1C05, 0, 0, K_DATA, 0, 0, 0, 0, 1});
		// Enable both interrupt sources
		rows.push_back('{0, WR, 'h0401, 3, 0, K_DATA, 0, 0, 0, 0, 1});
		// Random writes that alias the reset word and the mask
		rows.push_back('{C_RND, WR, 'h2010, 0, 0, K_DATA, 0, 0, 0, 0, 1});
		rows.push_back('{C_RND, WR, 'h0C01, 0, 0, K_DATA, 0, 0, 0, 0, 1});
		rows.push_back('{C_RND, WR, 'h2401, 0, 0, K_DATA, 0, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h0401, 0, 0, K_DATA | K_SYS, 0, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h0010, 0, 0, K_DATA, 3, 0, 0, 0, 1});
		rows.push_back('{0, NOP, 0, 0, 0, K_DATA | K_SYS, 0, 0, 0, 0, 1});
		// Both sources pulse and are claimed lowest first
		rows.push_back('{0, NOP, 0, 0, 'b11, K_IRQ | K_ACK, 0, 0, 0, 0, 1});
		// No request while intrdy_i is low
		rows.push_back('{C_NRDY, NOP, 0, 0, 0, K_IRQ, 0, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h0400, 0, 0, K_IRQ, 0, 1, 0, 0, 1});
		rows.push_back('{0, RD, 'h0400, 0, 0, K_ALL, 0, 1, 'b01, 0, 1});
		rows.push_back('{0, RD, 'h0400, 0, 0, K_ALL, 1, 0, 'b10, 0, 1});
		rows.push_back('{0, NOP, 0, 0, 0, K_ALL, 32'hFFFF_FFFF, 0, 0, 0, 1});
		// Mask cleared while both sources pulse
		rows.push_back('{0, WR, 'h0401, 0, 'b11, K_IRQ, 0, 0, 0, 0, 1});
		rows.push_back('{0, RD, 'h0401, 0, 0, K_IRQ, 0, 0, 0, 0, 1});
		rows.push_back('{0, NOP, 0, 0, 0, K_DATA | K_IRQ, 0, 0, 0, 0, 1});
		// Warm reset through the reset control word
		rows.push_back('{0, WR, 'h0010, 2, 0, K_SYS, 0, 0, 0, 0, 1});
		rows.push_back('{0, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 0, 1});
		rows.push_back('{0, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 1, 16});
		rows.push_back('{0, RD, 'h0010, 0, 0, K_SYS, 0, 0, 0, 0, 1});
		rows.push_back('{0, NOP, 0, 0, 0, K_ALL, 0, 0, 0, 0, 1});
		// Power-off stays until the board reset
		rows.push_back('{0, WR, 'h0010, 1, 0, K_SYS, 0, 0, 0, 0, 1});
		rows.push_back('{0, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 0, 1});
		rows.push_back('{0, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 1, 10});
		rows.push_back('{C_RST, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 1, 5});
		rows.push_back('{0, NOP, 0, 0, 0, K_SYS, 0, 0, 0, 1, 15});
		rows.push_back('{0, NOP, 0, 0, 0, K_ALL, 0, 0, 0, 0, 1});
		limit = 5 + 15 + 4 * rows.size() + 50;

		foreach (rows[k]) begin
			r = rows[k];
			for (int j = 0; j < r.n; j++) begin
				@(posedge clk48mhz_i);
				if (|(r.ctl & C_RND)) begin
					draw_word(wd);
				end else begin
					wd = r.wdata;
				end
				rst_p <= |(r.ctl & C_RST);
				cpu_rst_req_i <= |(r.ctl & C_CPU);
				intrdy_i <= ~|(r.ctl & C_NRDY);
				pi1_op_i <= r.op;
				pi1_addr_i <= (|(r.ctl & C_INC)) ? r.addr + PI1_ADDR_W'(j) : r.addr;
				pi1_data_i <= wd;
				intrqst_src_i <= r.src;
				// All outputs are settled mid-cycle
				@(negedge clk48mhz_i);
				if (r.chk[0]) check_val("pi1_data_o", pi1_data_o, r.e_data);
				if (r.chk[1]) check_val("intrqst_o", intrqst_o, r.e_irq);
				if (r.chk[2]) check_val("sys_rst_o", sys_rst_o, r.e_sys);
				if (r.chk[3]) check_val("intrdy_src_o", intrdy_src_o, r.e_ack);
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	always @(posedge clk48mhz_i) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: the table did not finish within %0d cycles", limit);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("Done: errors found");
			$finish;
		end
	end

endmodule
